// File: hdl/data_access_macros.svh
// data access stage widths and address map
// word size, register index widths and the two address-space select bits

`ifndef DATA_ACCESS_MACROS_SVH
`define DATA_ACCESS_MACROS_SVH

// ======================================================================
// word geometry
// ======================================================================
`define DA_XLEN              32    // data and address width
`define DA_XLEN_BYTES        4     // byte lanes per word

// ======================================================================
// register file and register bank
// ======================================================================
`define DA_REG_ADDR_BITS     5     // x0..x31
`define DA_MM_REG_ADDR_BITS  8     // word index into the register bank

// ======================================================================
// address spaces
// ======================================================================
`define DA_MEM_SPACE_BIT     31    // main memory select
`define DA_REG_SPACE_BIT     30    // register bank select

`endif

// File: hdl/data_access_pkg.sv
// data access stage types
// word, enable and index types plus the load/store width and FSM state enums

`default_nettype none

`include "data_access_macros.svh"

package data_access_pkg;

    // ======================================================================
    // data and index types
    // ======================================================================
    typedef logic [`DA_XLEN-1:0]             xlen_t;         // data or address word
    typedef logic [`DA_XLEN_BYTES-1:0]       byte_en_t;      // one bit per lane
    typedef logic [`DA_REG_ADDR_BITS-1:0]    reg_addr_t;     // register file index
    typedef logic [`DA_MM_REG_ADDR_BITS-1:0] mm_reg_addr_t;  // register bank word index

    // ======================================================================
    // access width, funct3 encoding
    // ======================================================================
    // codes 3, 6 and 7 are not named and fall through to word handling
    typedef enum logic [2:0] {
        LS_BYTE   = 3'd0,   // lb / sb
        LS_HALF   = 3'd1,   // lh / sh
        LS_WORD   = 3'd2,   // lw / sw
        LS_BYTE_U = 3'd4,   // lbu
        LS_HALF_U = 3'd5    // lhu
    } ls_width_t;

    // control states
    typedef enum logic [1:0] {
        ST_IDLE      = 2'd0,  // waiting for an enable
        ST_LOAD      = 2'd1,  // read issued, waiting for valid
        ST_EXCEPTION = 2'd2   // one cycle for the alignment fault
    } access_state_t;

endpackage

`default_nettype wire

// File: hdl/access_fsm.sv
// data access control
// idle/load/exception FSM, alignment check, request pulses and read strobes

`default_nettype none

module access_fsm (
    input  wire logic                       clk,
    input  wire logic                       reset_n,
    input  wire logic                       sync_reset,
    input  wire logic                       access_enable,
    input  wire logic                       load_active,
    input  wire logic                       store_active,
    input  wire data_access_pkg::ls_width_t width,
    input  wire logic [1:0]                 addr_low,     // byte offset
    input  wire logic                       mem_space,    // memory select bit
    input  wire logic                       reg_space,    // register bank select bit
    input  wire logic                       mem_valid,
    input  wire logic                       mm_reg_valid,
    output logic                            mem_we_req,
    output logic                            mem_re_req,
    output logic                            load_write,
    output logic                            mem_re,
    output logic                            mm_reg_re,
    output logic                            load_done,
    output logic                            exception_alignment
);

    data_access_pkg::access_state_t state;
    data_access_pkg::access_state_t next_state;
    logic                           misaligned;
    logic                           exc_start;   // misaligned access accepted

    // ======================================================================
    // alignment check
    // ======================================================================
    always_comb begin
        case (width)
            data_access_pkg::LS_BYTE,
            data_access_pkg::LS_BYTE_U: misaligned = 1'b0;          // any offset ok
            data_access_pkg::LS_HALF,
            data_access_pkg::LS_HALF_U: misaligned = addr_low[0];   // odd address
            default:                    misaligned = |addr_low;     // word, unknown codes
        endcase
    end

    // ======================================================================
    // next state and request pulses
    // ======================================================================
    always_comb begin
        next_state = state;
        mem_we_req = 1'b0;
        mem_re_req = 1'b0;
        load_write = 1'b0;
        exc_start  = 1'b0;
        case (state)
            data_access_pkg::ST_IDLE: begin
                // store wins when both are flagged
                if (access_enable && (store_active || load_active)) begin
                    if (misaligned) begin
                        exc_start  = 1'b1;
                        next_state = data_access_pkg::ST_EXCEPTION;
                    end else if (store_active) begin
                        mem_we_req = 1'b1;   // stays idle, next access may follow
                    end else begin
                        mem_re_req = 1'b1;
                        next_state = data_access_pkg::ST_LOAD;
                    end
                end
            end
            data_access_pkg::ST_LOAD: begin
                if (mem_valid || mm_reg_valid) begin
                    load_write = 1'b1;       // data present this cycle
                    next_state = data_access_pkg::ST_IDLE;
                end
            end
            data_access_pkg::ST_EXCEPTION: next_state = data_access_pkg::ST_IDLE;
            default:                       next_state = data_access_pkg::ST_IDLE;
        endcase
    end

    // state, registered bank read strobe and exception pulse
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state               <= data_access_pkg::ST_IDLE;
            mm_reg_re           <= 1'b0;
            exception_alignment <= 1'b0;
        end else if (sync_reset) begin
            state               <= data_access_pkg::ST_IDLE;
            mm_reg_re           <= 1'b0;
            exception_alignment <= 1'b0;
        end else begin
            state               <= next_state;
            mm_reg_re           <= mem_re_req & reg_space;   // one cycle after enable
            exception_alignment <= exc_start;
        end
    end

    assign mem_re    = mem_re_req & mem_space;  // same cycle as enable
    assign load_done = load_write;

    // ======================================================================
    // checks
    // ======================================================================
    // caller keeps the address steady while the read is out
    a_addr_held: assert property (@(posedge clk) disable iff (!reset_n)
        (state == data_access_pkg::ST_LOAD) |-> $stable({addr_low, mem_space, reg_space}));

    // responses only while a load is pending
    a_valid_in_load: assert property (@(posedge clk) disable iff (!reset_n)
        (mem_valid || mm_reg_valid) |-> (state == data_access_pkg::ST_LOAD));

endmodule

`default_nettype wire

// File: hdl/store_path.sv
// store data path
// byte enables, lane-shifted store data and register bank write strobes,
// all registered one cycle after the store request

`default_nettype none

`include "data_access_macros.svh"

module store_path (
    input  wire logic                       clk,
    input  wire logic                       reset_n,
    input  wire logic                       mem_we_req,
    input  wire data_access_pkg::ls_width_t width,
    input  wire data_access_pkg::xlen_t     access_addr,
    input  wire data_access_pkg::xlen_t     data_to_store,
    output data_access_pkg::byte_en_t       mem_we,
    output data_access_pkg::xlen_t          mem_wdata,
    output data_access_pkg::xlen_t          store_addr,
    output logic                            write_pending,
    output logic                            mm_reg_we,
    output data_access_pkg::mm_reg_addr_t   mm_reg_addr,
    output data_access_pkg::xlen_t          mm_reg_wdata,
    output logic                            store_done
);

    localparam int OFS_BITS = $clog2(`DA_XLEN_BYTES);

    logic [OFS_BITS-1:0]        offset;
    data_access_pkg::byte_en_t  lane_en;
    data_access_pkg::xlen_t     lane_data;

    assign offset = access_addr[OFS_BITS-1:0];

    // ======================================================================
    // lane enables and data shift
    // ======================================================================
    always_comb begin
        case (width)
            data_access_pkg::LS_BYTE,
            data_access_pkg::LS_BYTE_U: lane_en = 4'b0001 << offset;   // sb
            data_access_pkg::LS_HALF,
            data_access_pkg::LS_HALF_U: lane_en = 4'b0011 << offset;   // sh
            default:                    lane_en = 4'b1111;             // sw
        endcase
    end

    // low bytes move up into the addressed lanes
    assign lane_data = data_to_store << {offset, 3'b000};

    // ======================================================================
    // output registers
    // ======================================================================
    // strobes, cleared on reset
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mem_we        <= '0;
            mm_reg_we     <= 1'b0;
            store_done    <= 1'b0;
            write_pending <= 1'b0;
        end else begin
            // memory lanes only when the memory bit is set
            mem_we        <= {`DA_XLEN_BYTES{mem_we_req & access_addr[`DA_MEM_SPACE_BIT]}}
                             & lane_en;
            mm_reg_we     <= mem_we_req & access_addr[`DA_REG_SPACE_BIT];
            store_done    <= mem_we_req;
            write_pending <= mem_we_req;   // steers mem_addr to store_addr
        end
    end

    // payload, valid alongside the strobes
    always_ff @(posedge clk) begin
        mem_wdata    <= lane_data;
        store_addr   <= access_addr;
        mm_reg_wdata <= data_to_store;      // bank takes the full word
        mm_reg_addr  <= access_addr[`DA_MM_REG_ADDR_BITS+1:2];   // also used by loads
    end

    // ======================================================================
    // checks
    // ======================================================================
    // lane shift assumes a request aligned to its width
    a_req_aligned: assert property (@(posedge clk) disable iff (!reset_n)
        mem_we_req |-> (width inside {data_access_pkg::LS_BYTE, data_access_pkg::LS_BYTE_U})
            || (offset == '0)
            || ((width inside {data_access_pkg::LS_HALF, data_access_pkg::LS_HALF_U})
                && !offset[0]));

endmodule

`default_nettype wire

// File: hdl/load_writeback.sv
// load data path and register write-back
// picks the responding space, aligns and extends the loaded word, and muxes
// it against the pass-through rd result

`default_nettype none

`include "data_access_macros.svh"

module load_writeback (
    input  wire logic                       clk,
    input  wire logic                       reset_n,
    input  wire logic                       access_enable,
    input  wire data_access_pkg::ls_width_t width,
    input  wire logic [1:0]                 addr_low,
    input  wire logic                       mem_valid,
    input  wire data_access_pkg::xlen_t     mem_rdata,
    input  wire logic                       mm_reg_valid,
    input  wire data_access_pkg::xlen_t     mm_reg_rdata,
    input  wire logic                       load_write,
    input  wire logic                       save_to_rd,
    input  wire data_access_pkg::reg_addr_t rd_addr,
    input  wire data_access_pkg::xlen_t     rd_data,
    output logic                            reg_we,
    output data_access_pkg::reg_addr_t      reg_addr,
    output data_access_pkg::xlen_t          reg_wdata
);

    data_access_pkg::ls_width_t width_q;     // width of the access in flight
    logic [1:0]                 offset_q;    // its byte offset
    data_access_pkg::xlen_t     rdata_mux;
    data_access_pkg::xlen_t     rdata_shift;
    data_access_pkg::xlen_t     load_data;

    // ======================================================================
    // capture at enable
    // ======================================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            width_q  <= data_access_pkg::LS_WORD;
            offset_q <= 2'b00;
        end else if (access_enable) begin
            width_q  <= width;
            offset_q <= addr_low;
        end
    end

    // ======================================================================
    // align and extend
    // ======================================================================
    assign rdata_mux   = mem_valid ? mem_rdata : mm_reg_rdata;  // bank otherwise
    assign rdata_shift = rdata_mux >> {offset_q, 3'b000};       // addressed byte to lane 0

    always_comb begin
        case (width_q)
            data_access_pkg::LS_BYTE:
                load_data = {{(`DA_XLEN-8){rdata_shift[7]}}, rdata_shift[7:0]};
            data_access_pkg::LS_HALF:
                load_data = {{(`DA_XLEN-16){rdata_shift[15]}}, rdata_shift[15:0]};
            data_access_pkg::LS_BYTE_U:
                load_data = {{(`DA_XLEN-8){1'b0}}, rdata_shift[7:0]};
            data_access_pkg::LS_HALF_U:
                load_data = {{(`DA_XLEN-16){1'b0}}, rdata_shift[15:0]};
            default:
                load_data = rdata_shift;   // lw and unknown codes
        endcase
    end

    // ======================================================================
    // register file write
    // ======================================================================
    // load result wins, rd_data otherwise
    assign reg_we    = (access_enable & save_to_rd) | load_write;
    assign reg_wdata = load_write ? load_data : rd_data;
    assign reg_addr  = rd_addr;              // held by the caller during loads

    // one responder at a time
    a_valid_excl: assert property (@(posedge clk) disable iff (!reset_n)
        !(mem_valid && mm_reg_valid));

endmodule

`default_nettype wire

// File: hdl/data_access_top.sv
// data access stage top
// ties the control FSM to the store and load paths, muxes the memory address

`default_nettype none

`include "data_access_macros.svh"

module data_access_top (
    input  wire logic                         clk,
    input  wire logic                         reset_n,
    input  wire logic                         sync_reset,
    // from the execution unit
    input  wire logic                         access_enable,
    input  wire logic                         load_active,
    input  wire logic                         store_active,
    input  wire data_access_pkg::ls_width_t   width,
    input  wire data_access_pkg::xlen_t       access_addr,
    input  wire data_access_pkg::xlen_t       data_to_store,
    input  wire logic                         save_to_rd,
    input  wire data_access_pkg::reg_addr_t   rd_addr,
    input  wire data_access_pkg::xlen_t       rd_data,
    // memory
    input  wire logic                         mem_valid,
    input  wire data_access_pkg::xlen_t       mem_rdata,
    output logic                              mem_re,
    output data_access_pkg::byte_en_t         mem_we,
    output data_access_pkg::xlen_t           mem_addr,
    output data_access_pkg::xlen_t            mem_wdata,
    // register bank
    input  wire logic                         mm_reg_valid,
    input  wire data_access_pkg::xlen_t       mm_reg_rdata,
    output logic                              mm_reg_re,
    output logic                              mm_reg_we,
    output data_access_pkg::mm_reg_addr_t     mm_reg_addr,
    output data_access_pkg::xlen_t            mm_reg_wdata,
    // status
    output logic                              store_done,
    output logic                              load_done,
    output logic                              exception_alignment,
    // register file
    output logic                              reg_we,
    output data_access_pkg::reg_addr_t        reg_addr,
    output data_access_pkg::xlen_t            reg_wdata
);

    logic                   mem_we_req;     // store accepted
    logic                   mem_re_req;     // load accepted
    logic                   load_write;     // load data valid
    logic                   write_pending;  // store strobes out this cycle
    data_access_pkg::xlen_t store_addr;

    // ======================================================================
    // control
    // ======================================================================
    access_fsm u_fsm (
        .clk, .reset_n, .sync_reset, .access_enable, .load_active, .store_active, .width,
        .addr_low  (access_addr[1:0]),
        .mem_space (access_addr[`DA_MEM_SPACE_BIT]),
        .reg_space (access_addr[`DA_REG_SPACE_BIT]),
        .mem_valid, .mm_reg_valid, .mem_we_req, .mem_re_req, .load_write,
        .mem_re, .mm_reg_re, .load_done, .exception_alignment
    );

    // ======================================================================
    // data paths
    // ======================================================================
    store_path u_store (
        .clk, .reset_n, .mem_we_req, .width, .access_addr, .data_to_store,
        .mem_we, .mem_wdata, .store_addr, .write_pending,
        .mm_reg_we, .mm_reg_addr, .mm_reg_wdata, .store_done
    );

    load_writeback u_load (
        .clk, .reset_n, .access_enable, .width,
        .addr_low (access_addr[1:0]),
        .mem_valid, .mem_rdata, .mm_reg_valid, .mm_reg_rdata, .load_write,
        .save_to_rd, .rd_addr, .rd_data, .reg_we, .reg_addr, .reg_wdata
    );

    // registered store address while the write strobes are out
    assign mem_addr = write_pending ? store_addr : access_addr;

endmodule

`default_nettype wire

// File: test/tb_data_access.sv
// data access stage testbench
// random loads and stores to memory and the register bank, checked
// against a reference model, plus alignment faults and rd pass-through

`default_nettype none

module tb_data_access;
    timeunit 1ns;
    timeprecision 1ps;

    logic clk;
    logic reset_n;
    logic sync_reset;
    logic access_enable;
    logic load_active;
    logic store_active;
    data_access_pkg::ls_width_t    width;
    data_access_pkg::xlen_t        access_addr;
    data_access_pkg::xlen_t        data_to_store;
    logic save_to_rd;
    data_access_pkg::reg_addr_t    rd_addr;
    data_access_pkg::xlen_t        rd_data;
    logic mem_valid;
    data_access_pkg::xlen_t        mem_rdata;
    logic mem_re;
    data_access_pkg::byte_en_t     mem_we;
    data_access_pkg::xlen_t        mem_addr;
    data_access_pkg::xlen_t        mem_wdata;
    logic mm_reg_valid;
    data_access_pkg::xlen_t        mm_reg_rdata;
    logic mm_reg_re;
    logic mm_reg_we;
    data_access_pkg::mm_reg_addr_t mm_reg_addr;
    data_access_pkg::xlen_t        mm_reg_wdata;
    logic store_done;
    logic load_done;
    logic exception_alignment;
    logic reg_we;
    data_access_pkg::reg_addr_t    reg_addr;
    data_access_pkg::xlen_t        reg_wdata;

    integer seed = 37376;
    int     value_errors = 0;
    int     timeout_errors = 0;
    logic   hold_resp = 1'b0;                       // responders stay silent
    data_access_pkg::xlen_t        mem_model [64];  // main memory words
    data_access_pkg::xlen_t        bank_model [256];
    data_access_pkg::access_state_t fsm_state;
    data_access_pkg::ls_width_t    widths [5] = '{data_access_pkg::LS_BYTE,
        data_access_pkg::LS_HALF, data_access_pkg::LS_WORD,
        data_access_pkg::LS_BYTE_U, data_access_pkg::LS_HALF_U};

    data_access_top UUT (.*);

    always #5 clk = ~clk;
    always_comb fsm_state = UUT.u_fsm.state;        // shown in error lines

    // ======================================================================
    // responders
    // ======================================================================
    always begin : mem_responder
        data_access_pkg::xlen_t a;
        int d;
        @(posedge clk);
        if (mem_re && !hold_resp) begin
            a = mem_addr;
            d = $unsigned($random(seed)) % 4;       // 0..3 cycles late
            repeat (d) @(posedge clk);
            #1;
            mem_rdata = mem_model[a[7:2]];
            mem_valid = 1'b1;
            @(posedge clk);
            #1 mem_valid = 1'b0;
        end
    end

    always begin : bank_responder
        data_access_pkg::mm_reg_addr_t a;
        int d;
        @(posedge clk);
        if (mm_reg_re && !hold_resp) begin
            a = mm_reg_addr;
            d = $unsigned($random(seed)) % 4;
            repeat (d) @(posedge clk);
            #1;
            mm_reg_rdata = bank_model[a];
            mm_reg_valid = 1'b1;
            @(posedge clk);
            #1 mm_reg_valid = 1'b0;
        end
    end

    // ======================================================================
    // reference model
    // ======================================================================
    function automatic int size_of(data_access_pkg::ls_width_t w);
        if (w == data_access_pkg::LS_BYTE || w == data_access_pkg::LS_BYTE_U) return 1;
        if (w == data_access_pkg::LS_HALF || w == data_access_pkg::LS_HALF_U) return 2;
        return 4;
    endfunction

    function automatic data_access_pkg::byte_en_t expect_byte_en(
            data_access_pkg::ls_width_t w, int off);
        data_access_pkg::byte_en_t en;
        en = '0;
        for (int i = 0; i < 4; i++)
            en[i] = (i >= off) && (i < off + size_of(w));
        return en;
    endfunction

    // data bytes placed from lane off upward
    function automatic data_access_pkg::xlen_t expect_lanes(data_access_pkg::xlen_t d, int off);
        data_access_pkg::xlen_t r;
        r = '0;
        for (int i = off; i < 4; i++)
            r[8*i +: 8] = d[8*(i-off) +: 8];
        return r;
    endfunction

    function automatic data_access_pkg::xlen_t expect_load(data_access_pkg::xlen_t word,
            data_access_pkg::ls_width_t w, int off);
        data_access_pkg::xlen_t r;
        int n;
        n = size_of(w);
        r = '0;
        for (int i = 0; i < n; i++)
            r[8*i +: 8] = word[8*(off+i) +: 8];
        if ((w == data_access_pkg::LS_BYTE || w == data_access_pkg::LS_HALF) && r[8*n-1])
            for (int b = 8*n; b < 32; b++)
                r[b] = 1'b1;                        // sign fill
        return r;
    endfunction

    function automatic data_access_pkg::xlen_t make_addr(logic bank, int idx, int off);
        if (bank) return 32'h4000_0000 | ((idx & 255) << 2) | off;
        return 32'h8000_0000 | ((idx & 63) << 2) | off;
    endfunction

    // ======================================================================
    // compare tasks
    // ======================================================================
    task automatic check_word(data_access_pkg::xlen_t got, data_access_pkg::xlen_t exp,
            string what);
        if (got !== exp) begin
            $display("ERROR %0t: %s got %h expected %h (state %s)", $time, what, got,
                exp, fsm_state.name());
            value_errors++;
        end
    endtask

    task automatic check_byte_en(data_access_pkg::byte_en_t got,
            data_access_pkg::byte_en_t exp, string what);
        if (got !== exp) begin
            $display("ERROR %0t: %s got %b expected %b", $time, what, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_reg_addr(data_access_pkg::reg_addr_t got,
            data_access_pkg::reg_addr_t exp, string what);
        if (got !== exp) begin
            $display("ERROR %0t: %s got %0d expected %0d", $time, what, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_bit(logic got, logic exp, string what);
        if (got !== exp) begin
            $display("ERROR %0t: %s got %b expected %b (state %s)", $time, what, got, exp,
                fsm_state.name());
            value_errors++;
        end
    endtask

    // ======================================================================
    // stimulus helpers
    // ======================================================================
    task automatic start_access(logic ld, logic st, data_access_pkg::ls_width_t w,
            data_access_pkg::xlen_t a, data_access_pkg::xlen_t d);
        @(posedge clk);
        #1;
        access_enable = 1'b1;
        load_active   = ld;
        store_active  = st;
        width         = w;
        access_addr   = a;
        data_to_store = d;
        rd_addr       = $random(seed);
    endtask

    // 0 store_done, 1 load_done, 2 exception_alignment
    task automatic wait_pulse(int which, int limit, output int cycles);
        logic found;
        found  = 1'b0;
        cycles = 0;
        while (!found && cycles < limit) begin
            @(posedge clk);
            #1;
            access_enable = 1'b0;
            save_to_rd    = 1'b0;
            #1;
            cycles++;
            found = (which == 0) ? store_done : (which == 1) ? load_done : exception_alignment;
        end
        if (!found) begin
            $display("timeout: pulse %0d never came within %0d cycles", which, limit);
            timeout_errors++;
        end
    endtask

    task automatic do_store(logic bank, data_access_pkg::ls_width_t w, int idx, int off);
        data_access_pkg::xlen_t a;
        data_access_pkg::xlen_t d;
        data_access_pkg::xlen_t lanes;
        data_access_pkg::byte_en_t en;
        int n;
        a     = make_addr(bank, idx, off);
        d     = $random(seed);
        lanes = expect_lanes(d, off);
        en    = bank ? 4'b0000 : expect_byte_en(w, off);
        start_access(1'b0, 1'b1, w, a, d);
        wait_pulse(0, 4, n);
        check_bit(n == 1, 1'b1, "store_done one cycle after enable");
        check_byte_en(mem_we, en, "mem_we");
        check_bit(mm_reg_we, bank, "mm_reg_we");
        if (bank) begin
            check_word(mm_reg_wdata, d, "mm_reg_wdata");
            check_word(32'(mm_reg_addr), a[9:2], "mm_reg_addr");
            bank_model[a[9:2]] = d;                 // full word
        end else begin
            check_word(mem_wdata & expect_lanes('1, off), lanes & expect_lanes('1, off),
                "mem_wdata");
            check_word(mem_addr, a, "mem_addr");
            for (int i = 0; i < 4; i++)
                if (en[i]) mem_model[a[7:2]][8*i +: 8] = lanes[8*i +: 8];
        end
    endtask

    task automatic do_load(logic bank, data_access_pkg::ls_width_t w, int idx, int off);
        data_access_pkg::xlen_t a;
        data_access_pkg::xlen_t word;
        int n;
        a    = make_addr(bank, idx, off);
        word = bank ? bank_model[a[9:2]] : mem_model[a[7:2]];
        start_access(1'b1, 1'b0, w, a, '0);
        #1 check_bit(mem_re, !bank, "mem_re in enable cycle");
        check_word(mem_addr, a, "mem_addr in enable cycle");
        if (bank) begin
            // bank read strobe comes one cycle late
            @(posedge clk);
            #1 access_enable = 1'b0;
            #1 check_bit(mm_reg_re, 1'b1, "mm_reg_re one cycle after enable");
            check_word(32'(mm_reg_addr), a[9:2], "mm_reg_addr on load");
        end
        wait_pulse(1, 12, n);
        check_bit(reg_we, 1'b1, "reg_we on load_done");
        check_reg_addr(reg_addr, rd_addr, "reg_addr");
        check_word(reg_wdata, expect_load(word, w, off), "reg_wdata load");
        check_byte_en(mem_we, 4'b0000, "mem_we during load");
    endtask

    task automatic do_misaligned(data_access_pkg::ls_width_t w, int off);
        int n;
        start_access($random(seed), $random(seed), w,
            make_addr($random(seed), $random(seed), off), 0);
        load_active = !store_active | load_active;
        #1 check_bit(mem_re, 1'b0, "mem_re on misaligned");
        wait_pulse(2, 4, n);
        check_bit(n == 1, 1'b1, "exception one cycle after enable");
        check_byte_en(mem_we, 4'b0000, "mem_we on misaligned");
        check_bit(mm_reg_we | mm_reg_re | store_done | reg_we, 1'b0, "strobes on misaligned");
    endtask

    task automatic do_pass_through();
        data_access_pkg::xlen_t d;
        d = $random(seed);
        start_access(1'b0, 1'b0, data_access_pkg::LS_WORD, '0, '0);
        save_to_rd = 1'b1;
        rd_data    = d;
        #1;
        check_bit(reg_we, 1'b1, "reg_we pass-through");
        check_reg_addr(reg_addr, rd_addr, "reg_addr pass-through");
        check_word(reg_wdata, d, "reg_wdata pass-through");
    endtask

    task automatic check_quiet(string when);
        check_bit(mem_re | mm_reg_re | mm_reg_we | store_done | load_done, 1'b0, when);
        check_bit(exception_alignment | reg_we, 1'b0, when);
        check_byte_en(mem_we, 4'b0000, when);
    endtask

    // ======================================================================
    // main sequence
    // ======================================================================
    initial begin
        int op;
        int off;
        data_access_pkg::ls_width_t w;
        clk           = 0;
        reset_n       = 0;
        sync_reset    = 0;
        access_enable = 0;
        load_active   = 0;
        store_active  = 0;
        width         = data_access_pkg::LS_WORD;
        access_addr   = '0;
        data_to_store = '0;
        save_to_rd    = 0;
        rd_addr       = '0;
        rd_data       = '0;
        mem_valid     = 0;
        mem_rdata     = '0;
        mm_reg_valid  = 0;
        mm_reg_rdata  = '0;
        for (int i = 0; i < 64; i++)
            mem_model[i] = make_addr(0, i, 0) ^ (make_addr(0, i, 0) << 13) ^ 32'h5a5a_0000;
        for (int i = 0; i < 256; i++)
            bank_model[i] = make_addr(1, i, 0) ^ (make_addr(1, i, 0) >> 7) ^ 32'h0000_c3c3;

        repeat (16) @(posedge clk);
        #1 reset_n = 1'b1;
        #1 check_quiet("after reset");

        // every width at every offset
        for (int wi = 0; wi < 5; wi++)
            for (int o = 0; o < 4; o++)
                if (o % size_of(widths[wi]) == 0) begin
                    do_store(1'b0, widths[wi], wi * 4 + o, o);
                    do_load(1'b0, widths[wi], wi * 4 + o, o);
                end else
                    do_misaligned(widths[wi], o);

        for (int k = 0; k < 300; k++) begin
            op  = $unsigned($random(seed)) % 6;
            w   = widths[$unsigned($random(seed)) % 5];
            off = ($unsigned($random(seed)) % 4) & (size_of(w) == 4 ? 0 :
                  size_of(w) == 2 ? 2 : 3);         // legal offsets only
            case (op)
                0: do_store(1'b0, w, $random(seed), off);
                1: do_load(1'b0, w, $random(seed), off);
                2: do_store(1'b1, w, $random(seed), off);
                3: do_load(1'b1, w, $random(seed), off);
                4: if (size_of(w) > 1) do_misaligned(w, (size_of(w) == 2) ? 1 + 2 * (k % 2) :
                       1 + k % 3);
                default: do_pass_through();
            endcase
        end

        // sync_reset in the middle of a load
        hold_resp = 1'b1;
        start_access(1'b1, 1'b0, data_access_pkg::LS_WORD, make_addr(0, 5, 0), '0);
        @(posedge clk);
        #1 access_enable = 1'b0;
        sync_reset = 1'b1;
        @(posedge clk);
        #1 sync_reset = 1'b0;
        load_active = 1'b0;
        repeat (4) begin
            @(posedge clk);
            #2 check_quiet("after sync_reset");
            check_bit(fsm_state == data_access_pkg::ST_IDLE, 1'b1, "idle after sync_reset");
        end
        hold_resp = 1'b0;
        do_store(1'b0, data_access_pkg::LS_WORD, 9, 0);

        $display("errors: value %0d, timeout %0d", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+hdl
hdl/data_access_pkg.sv
hdl/access_fsm.sv
hdl/store_path.sv
hdl/load_writeback.sv
hdl/data_access_top.sv
test/tb_data_access.sv

// File: run_sim.sh
#!/bin/sh
# build and run the data access stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f files.f --top-module tb_data_access -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_data_access)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^=== PASS ===$"; then
    exit 0
fi
exit 1
